// ==== verilog/oflow_pkg.sv ====
// feature record widths for one bounding box and one row
// bank geometry and address split of the feature store
// field and bank views of one box word
`default_nettype none

package oflow_pkg;

  localparam int id_len               = 15;
  localparam int coord_len            = 11;               // one corner coordinate
  localparam int cm_concate_len       = 22;               // cm x and y
  localparam int position_concate_len = 4 * coord_len;    // four corners, 44
  localparam int dim_len              = 11;               // width or height
  localparam int color_len            = 21;
  localparam int shape_color_len      = 2 * dim_len + 2 * color_len;  // 64

  localparam int bbox_len       = id_len + cm_concate_len + position_concate_len
                                  + shape_color_len;      // 145
  localparam int boxes_per_row  = 2;
  localparam int row_len        = boxes_per_row * bbox_len;  // 290
  localparam int id_cm_len      = id_len + cm_concate_len;   // 37, bank 0 word

  // sram banks
  localparam int bank_width    = 64;
  localparam int addr_width    = 8;
  localparam int ram_depth     = 1 << addr_width;
  localparam int num_banks     = 6;
  localparam int banks_per_box = 3;

  // address inside one frame half
  localparam int pair_width = 6;  // write pair index
  localparam int row_width  = 7;  // row index, pair plus even/odd bit

  typedef struct packed {
    logic [dim_len-1:0]   width;
    logic [dim_len-1:0]   height;
    logic [color_len-1:0] color1;
    logic [color_len-1:0] color2;
  } shape_color_t;

  // feature view of one box
  typedef struct packed {
    logic [id_len-1:0]               id;
    logic [cm_concate_len-1:0]       cm;
    logic [position_concate_len-1:0] position;
    shape_color_t                    shape_color;
  } bbox_fields_t;

  // storage view, one member per bank
  typedef struct packed {
    logic [id_cm_len-1:0]            id_cm;
    logic [position_concate_len-1:0] pos;
    logic [shape_color_len-1:0]      shape_color;
  } bbox_banks_t;

  typedef union packed {
    bbox_fields_t fields;
    bbox_banks_t  banks;
  } bbox_word_u;

endpackage

`default_nettype wire

// ==== verilog/bank_port_if.sv ====
// one sram port shared by all six banks
// modports for controller, packer, banks and unpacker
`timescale 1ns/10ps
`default_nettype none

interface bank_port_if;
  import oflow_pkg::*;

  logic [addr_width-1:0] addr;                // same row in every bank
  logic [bank_width-1:0] din  [num_banks];    // one lane per bank
  logic [bank_width-1:0] dout [num_banks];
  logic                  cs;                  // chip select, active high
  logic                  we;                  // write enable
  logic                  oe;                  // output enable

  modport ctrl (output addr, output cs, output we, output oe);

  modport pack (output din);

  modport ram (
    input  addr,
    input  din,
    input  cs,
    input  we,
    input  oe,
    output dout
  );

  modport unpack (input dout);

endinterface

`default_nettype wire

// ==== verilog/feature_store_ctrl.sv ====
// feature store controller
// frame half flop, write and read addresses, bank strobes
// read request stage and valid shift register
`timescale 1ns/10ps
`default_nettype none

module feature_store_ctrl (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr_en,
  input  logic [oflow_pkg::pair_width-1:0] wr_pair,
  input  logic                             rd_en,
  input  logic [oflow_pkg::row_width-1:0]  rd_row,
  input  logic                             frame_swap,
  output logic                             frame_sel,
  output logic                             rd_load,    // first valid stage
  output logic                             rd_valid,
  bank_port_if.ctrl                        port_a,
  bank_port_if.ctrl                        port_b
);
  import oflow_pkg::*;

  logic                  rd_req;        // read owns port a this cycle
  logic [addr_width-1:0] rd_addr_q;     // half latched with the request
  logic [addr_width-1:0] wr_addr_even;
  logic [addr_width-1:0] wr_addr_odd;

  // frame half, writes go to frame_sel and reads to the other half
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_sel <= 1'b0;
    end else if (frame_swap) begin
      frame_sel <= ~frame_sel;
    end
  end

  // request -> bank read -> unpacker load -> valid
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_req   <= 1'b0;
      rd_load  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_req   <= rd_en;
      rd_load  <= rd_req;   // dout of the banks is ready here
      rd_valid <= rd_load;  // rd_data registered one edge earlier
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_addr_q <= {~frame_sel, rd_row};  // previous frame
    end
  end

  // even row of the pair on port a, odd row on port b
  assign wr_addr_even = {frame_sel, wr_pair, 1'b0};
  assign wr_addr_odd  = {frame_sel, wr_pair, 1'b1};

  // read beats a write for port a
  assign port_a.addr = rd_req ? rd_addr_q : wr_addr_even;
  assign port_a.cs   = rd_req | wr_en;
  assign port_a.we   = wr_en & ~rd_req;
  assign port_a.oe   = rd_req;

  // port b only ever writes
  assign port_b.addr = wr_addr_odd;
  assign port_b.cs   = wr_en;
  assign port_b.we   = wr_en;
  assign port_b.oe   = 1'b0;

  // no reads issued while the pipe is in reset
  a_no_rd_in_rst : assert property (@(posedge clk) rst |-> !rd_en);

  // a write in the read's bank cycle would drop its even row
  a_no_wr_on_rd : assert property (
    @(posedge clk) disable iff (rst) rd_en |=> !wr_en
  );

endmodule

`default_nettype wire

// ==== verilog/bbox_bank_packer.sv ====
// splits a two box row into six bank words for one write port
// left box to banks 0..2, right box to banks 3..5
`timescale 1ns/10ps
`default_nettype none

module bbox_bank_packer (
  input  logic [oflow_pkg::row_len-1:0] row,
  bank_port_if.pack                     port
);
  import oflow_pkg::*;

  bbox_word_u boxes [boxes_per_row];  // index 0 is the left box

  for (genvar i = 0; i < boxes_per_row; i++) begin : g_box
    localparam int base = i * banks_per_box;       // first bank of this box
    localparam int lsb  = (boxes_per_row - 1 - i) * bbox_len;

    assign boxes[i] = row[lsb +: bbox_len];        // left box sits on top

    // narrow words zero padded up to the bank width
    assign port.din[base]     = bank_width'(boxes[i].banks.id_cm);
    assign port.din[base + 1] = bank_width'(boxes[i].banks.pos);
    assign port.din[base + 2] = boxes[i].banks.shape_color;  // already full width
  end

endmodule

`default_nettype wire

// ==== verilog/feature_bank_ram.sv ====
// one 256x64 dual port sram bank, behavioural
// cs/we write, cs/oe read into this bank's dout lane
`timescale 1ns/10ps
`default_nettype none

module feature_bank_ram #(
  parameter int bank_idx = 0  // lane of din and dout
) (
  input  logic     clk,
  bank_port_if.ram a,
  bank_port_if.ram b
);
  import oflow_pkg::*;

  logic [bank_width-1:0] mem [ram_depth];  // contents undefined until written
  logic [bank_width-1:0] q_a;
  logic [bank_width-1:0] q_b;

  // both ports may write in one cycle, to different rows
  always_ff @(posedge clk) begin
    if (a.cs && a.we) begin
      mem[a.addr] <= a.din[bank_idx];
    end
    if (b.cs && b.we) begin
      mem[b.addr] <= b.din[bank_idx];
    end
  end

  // read word held until the next read
  always_ff @(posedge clk) begin
    if (a.cs && a.oe && !a.we) begin
      q_a <= mem[a.addr];
    end
    if (b.cs && b.oe && !b.we) begin
      q_b <= mem[b.addr];
    end
  end

  assign a.dout[bank_idx] = q_a;
  assign b.dout[bank_idx] = q_b;

  // even and odd rows of a pair, so never the same row
  a_no_addr_clash : assert property (
    @(posedge clk) (a.cs && a.we && b.cs && b.we) |-> (a.addr != b.addr)
  );

endmodule

`default_nettype wire

// ==== verilog/bbox_bank_unpacker.sv ====
// rebuilds a 290 bit row from the six bank read words
// output row register loaded on the first valid stage
`timescale 1ns/10ps
`default_nettype none

module bbox_bank_unpacker (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,     // bank words valid this cycle
  bank_port_if.unpack                   port,
  output logic [oflow_pkg::row_len-1:0] rd_data
);
  import oflow_pkg::*;

  bbox_word_u boxes [boxes_per_row];  // 0 left, 1 right
  logic       load_q;                 // rd_data freshly loaded, tracks rd_valid

  // drop the padding and refill the bank view
  always_comb begin
    for (int i = 0; i < boxes_per_row; i++) begin
      boxes[i].banks.id_cm       = port.dout[i * banks_per_box][id_cm_len-1:0];
      boxes[i].banks.pos         =
        port.dout[i * banks_per_box + 1][position_concate_len-1:0];
      boxes[i].banks.shape_color = port.dout[i * banks_per_box + 2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (load) begin
      rd_data <= {boxes[0], boxes[1]};  // left box in the upper half
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      load_q <= 1'b0;
    end else begin
      load_q <= load;
    end
  end

  // a written row never comes back with unknown bits
  a_rd_data_known : assert property (
    @(posedge clk) disable iff (rst) load_q |-> !$isunknown(rd_data)
  );

endmodule

`default_nettype wire

// ==== verilog/feature_store_top.sv ====
// feature store top level
// controller, two write packers, six banks, read unpacker
`timescale 1ns/10ps
`default_nettype none

module feature_store_top (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr_en,       // write pair strobe
  input  logic [oflow_pkg::pair_width-1:0] wr_pair,
  input  logic [oflow_pkg::row_len-1:0]    wr_row0,     // to row 2*wr_pair
  input  logic [oflow_pkg::row_len-1:0]    wr_row1,     // to row 2*wr_pair+1
  input  logic                             rd_en,       // read strobe
  input  logic [oflow_pkg::row_width-1:0]  rd_row,
  input  logic                             frame_swap,
  output logic [oflow_pkg::row_len-1:0]    rd_data,
  output logic                             rd_valid,    // 2 cycles after rd_en
  output logic                             frame_sel
);
  import oflow_pkg::*;

  logic rd_load;  // bank words ready, load unpacker

  bank_port_if port_a ();  // even row writes and all reads
  bank_port_if port_b ();  // odd row writes

  feature_store_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_pair    (wr_pair),
    .rd_en      (rd_en),
    .rd_row     (rd_row),
    .frame_swap (frame_swap),
    .frame_sel  (frame_sel),
    .rd_load    (rd_load),
    .rd_valid   (rd_valid),
    .port_a     (port_a),
    .port_b     (port_b)
  );

  bbox_bank_packer u_pack_even (
    .row  (wr_row0),
    .port (port_a)
  );

  bbox_bank_packer u_pack_odd (
    .row  (wr_row1),
    .port (port_b)
  );

  // 0..2 left box, 3..5 right box
  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    feature_bank_ram #(
      .bank_idx (i)
    ) u_bank (
      .clk (clk),
      .a   (port_a),
      .b   (port_b)
    );
  end

  bbox_bank_unpacker u_unpack (
    .clk     (clk),
    .rst     (rst),
    .load    (rd_load),
    .port    (port_a),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_feature_store.sv ====
// testbench for the feature store top level
// file driven writes, swaps and reads, reference array of both halves
// field by field checks of every returned row
`timescale 1ns/10ps
`default_nettype none

module tb_feature_store;
  import oflow_pkg::*;

  localparam int timeout_cycles = 10;  // max idle cycles waiting for rd_valid
  localparam int rd_latency     = 2;   // edges from rd_en sample to rd_valid

  logic                  clk;
  logic                  rst;
  logic                  wr_en;
  logic [pair_width-1:0] wr_pair;
  logic [row_len-1:0]    wr_row0;
  logic [row_len-1:0]    wr_row1;
  logic                  rd_en;
  logic [row_width-1:0]  rd_row;
  logic                  frame_swap;
  logic [row_len-1:0]    rd_data;
  logic                  rd_valid;
  logic                  frame_sel;

  logic [row_len-1:0]   ref_mem [ram_depth];  // model of both frame halves
  logic                 half;                 // expected frame_sel
  int                   errors;
  int                   checks;
  bit                   timed_out;
  int                   fd;
  logic [row_width-1:0] rq_row [$];           // pending read batch
  logic [row_len-1:0]   rq_exp [$];

  feature_store_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_pair    (wr_pair),
    .wr_row0    (wr_row0),
    .wr_row1    (wr_row1),
    .rd_en      (rd_en),
    .rd_row     (rd_row),
    .frame_swap (frame_swap),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .frame_sel  (frame_sel)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_box(input string side, input bbox_word_u exp, input bbox_word_u act);
    check_val({side, ".id"}, exp.fields.id, act.fields.id);
    check_val({side, ".cm"}, exp.fields.cm, act.fields.cm);
    check_val({side, ".position"}, exp.fields.position, act.fields.position);
    check_val({side, ".width"}, exp.fields.shape_color.width, act.fields.shape_color.width);
    check_val({side, ".height"}, exp.fields.shape_color.height,
              act.fields.shape_color.height);
    check_val({side, ".color1"}, exp.fields.shape_color.color1,
              act.fields.shape_color.color1);
    check_val({side, ".color2"}, exp.fields.shape_color.color2,
              act.fields.shape_color.color2);
  endtask

  // one box line: id cm position width height color1 color2
  task automatic read_box(output bbox_word_u box);
    logic [63:0] v [7];
    int          n;
    n = 0;
    for (int i = 0; i < 7; i++) begin
      n += $fscanf(fd, "%h", v[i]);
    end
    if (n != 7) begin
      errors++;
      $display("test file has a box line with missing fields");
    end
    box.fields.id                 = v[0][id_len-1:0];
    box.fields.cm                 = v[1][cm_concate_len-1:0];
    box.fields.position           = v[2][position_concate_len-1:0];
    box.fields.shape_color.width  = v[3][dim_len-1:0];
    box.fields.shape_color.height = v[4][dim_len-1:0];
    box.fields.shape_color.color1 = v[5][color_len-1:0];
    box.fields.shape_color.color2 = v[6][color_len-1:0];
  endtask

  task automatic do_write(input logic [pair_width-1:0] pair, input bit rnd);
    bbox_word_u  box [4];       // row0 left/right, row1 left/right
    logic [31:0] rnd_word;
    for (int i = 0; i < 4; i++) begin
      read_box(box[i]);
      if (rnd) begin
        rnd_word = $urandom();
        box[i].fields.shape_color.color1 = rnd_word[color_len-1:0];
        rnd_word = $urandom();
        box[i].fields.shape_color.color2 = rnd_word[color_len-1:0];
      end
    end
    ref_mem[{half, pair, 1'b0}] = {box[0], box[1]};  // current half
    ref_mem[{half, pair, 1'b1}] = {box[2], box[3]};
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_pair <= pair;
    wr_row0 <= {box[0], box[1]};
    wr_row1 <= {box[2], box[3]};
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic do_swap();
    @(posedge clk);
    frame_swap <= 1'b1;
    @(posedge clk);
    frame_swap <= 1'b0;
    half = ~half;
    @(negedge clk);
    check_val("frame_sel", half, frame_sel);
  endtask

  // expected row from the file, colours from the model when random
  task automatic queue_read(input logic [row_width-1:0] row, input bit rnd);
    bbox_word_u exp_l;
    bbox_word_u exp_r;
    bbox_word_u mdl_l;
    bbox_word_u mdl_r;
    read_box(exp_l);
    read_box(exp_r);
    {mdl_l, mdl_r} = ref_mem[{~half, row}];  // previous frame
    if (rnd) begin
      exp_l.fields.shape_color.color1 = mdl_l.fields.shape_color.color1;
      exp_l.fields.shape_color.color2 = mdl_l.fields.shape_color.color2;
      exp_r.fields.shape_color.color1 = mdl_r.fields.shape_color.color1;
      exp_r.fields.shape_color.color2 = mdl_r.fields.shape_color.color2;
    end
    rq_row.push_back(row);
    rq_exp.push_back({exp_l, exp_r});
  endtask

  // issue the batch back to back, collect rows as rd_valid arrives
  task automatic run_reads();
    int         issue_edge [$];
    int         issued;
    int         got;
    int         t;
    int         idle;
    bbox_word_u exp_l;
    bbox_word_u exp_r;
    bbox_word_u got_l;
    bbox_word_u got_r;
    issued = 0;
    got    = 0;
    t      = 0;
    idle   = 0;
    while (got < rq_row.size() && !timed_out) begin
      @(posedge clk);
      t++;
      if (issued < rq_row.size()) begin
        rd_en  <= 1'b1;
        rd_row <= rq_row[issued];
        issue_edge.push_back(t + 1);  // dut samples at the next edge
        issued++;
      end else begin
        rd_en <= 1'b0;
      end
      @(negedge clk);
      if (rd_valid) begin
        check_val("rd_latency", rd_latency, t - issue_edge[got]);
        {exp_l, exp_r} = rq_exp[got];
        {got_l, got_r} = rd_data;
        check_box("rd_data.left", exp_l, got_l);
        check_box("rd_data.right", exp_r, got_r);
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > timeout_cycles) begin
          errors++;
          timed_out = 1'b1;
          $display("timeout: rd_valid never came for the read of row %0d", rq_row[got]);
        end
      end
    end
    if (!timed_out) begin
      @(negedge clk);
      check_val("rd_valid", 0, rd_valid);  // one beat per read, none extra
    end
    rq_row.delete();
    rq_exp.delete();
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_val("rd_valid", 0, rd_valid);
      check_val("frame_sel", 0, frame_sel);
      check_val("rd_data (any bit set)", 0, |rd_data);
    end
  endtask

  initial begin
    string cmd;
    string rest;
    int    arg;
    int    rnd;
    int    code;
    int    seed;
    errors     = 0;
    checks     = 0;
    timed_out  = 1'b0;
    half       = 1'b0;
    rst        = 1'b1;
    wr_en      = 1'b0;
    wr_pair    = '0;
    wr_row0    = '0;
    wr_row1    = '0;
    rd_en      = 1'b0;
    rd_row     = '0;
    frame_swap = 1'b0;
    seed       = 32'hc2f4_fe3c;
    void'($urandom(seed));
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    check_idle(4);  // no stimulus yet
    fd = $fopen("testbench/feature_store_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open testbench/feature_store_tests.txt");
    end else begin
      while (!timed_out && $fscanf(fd, "%s", cmd) == 1) begin
        if (cmd != "R" && rq_row.size() > 0) begin
          run_reads();  // a batch ends at the first non read line
        end
        if (cmd == "W") begin
          code = $fscanf(fd, "%d %d", arg, rnd);
          if (code != 2) begin
            errors++;
            $display("test file has a W line without its pair and rnd numbers");
          end
          do_write(arg[pair_width-1:0], rnd != 0);
        end else if (cmd == "S") begin
          do_swap();
        end else if (cmd == "R") begin
          code = $fscanf(fd, "%d %d", arg, rnd);
          if (code != 2) begin
            errors++;
            $display("test file has an R line without its row and rnd numbers");
          end
          queue_read(arg[row_width-1:0], rnd != 0);
        end else if (cmd[0] == "#") begin
          code = $fgets(rest, fd);  // rest of a comment line
        end else begin
          errors++;
          $display("unknown command %s in the test file", cmd);
        end
      end
      if (!timed_out && rq_row.size() > 0) begin
        run_reads();
      end
      $fclose(fd);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/feature_store_tests.txt ====
# commands: W pair rnd, S, R row rnd; W and R are followed by box lines, left box first
# box line in hex: id cm position width height color1 color2; rnd 1 means random colours
W 0 0
0011 0a0b01 00123456789 011 022 012345 054321
0022 1a0b02 0aabbccddee 133 144 1abcde 0fedcb
0033 2a0b03 11122233344 255 266 100001 0a5a5a
0044 3a0b04 7ff0000fff0 3ff 7ff 1fffff 000001
W 3 1
0155 000001 00000000001 001 002 0 0
7fff 3fffff fffffffffff 7ff 7ff 0 0
0166 123456 0f0f0f0f0f0 0aa 055 0 0
0177 234567 0e0e0e0e0e0 0bb 066 0 0
S
R 0 0
0011 0a0b01 00123456789 011 022 012345 054321
0022 1a0b02 0aabbccddee 133 144 1abcde 0fedcb
R 1 0
0033 2a0b03 11122233344 255 266 100001 0a5a5a
0044 3a0b04 7ff0000fff0 3ff 7ff 1fffff 000001
R 6 1
0155 000001 00000000001 001 002 0 0
7fff 3fffff fffffffffff 7ff 7ff 0 0
R 7 1
0166 123456 0f0f0f0f0f0 0aa 055 0 0
0177 234567 0e0e0e0e0e0 0bb 066 0 0
W 0 0
0211 0c0d01 5555555555a 0a1 0b2 0c0c0c 0d0d0d
0222 0c0d02 2222222222b 0a3 0b4 0e0e0e 0f0f0f
0233 0c0d03 33333333333 0a5 0b6 101010 111111
0244 0c0d04 44444444444 0a7 0b8 121212 131313
R 0 0
0011 0a0b01 00123456789 011 022 012345 054321
0022 1a0b02 0aabbccddee 133 144 1abcde 0fedcb
S
R 0 0
0211 0c0d01 5555555555a 0a1 0b2 0c0c0c 0d0d0d
0222 0c0d02 2222222222b 0a3 0b4 0e0e0e 0f0f0f
R 1 0
0233 0c0d03 33333333333 0a5 0b6 101010 111111
0244 0c0d04 44444444444 0a7 0b8 121212 131313

// ==== build.f ====
verilog/oflow_pkg.sv
verilog/bank_port_if.sv
verilog/feature_store_ctrl.sv
verilog/bbox_bank_packer.sv
verilog/feature_bank_ram.sv
verilog/bbox_bank_unpacker.sv
verilog/feature_store_top.sv
testbench/tb_feature_store.sv
